//--- common/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 16
`define INDEX_BITS 4

// Line size in bits and byte offset width
`define LINE_BITS 512
`define OFFSET_BITS 6

// Request address and data widths
`define ADDR_BITS 32
`define WORD_BITS 32

// Tag is what is left above index and offset
`define TAG_BITS (`ADDR_BITS - `INDEX_BITS - `OFFSET_BITS)

`endif

//--- common/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

    typedef enum logic {
        LD = 1'b0,
        ST = 1'b1
    } op_t;

    // Same encoding as the requester's size field
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } size_t;

    // All-zero entry reads as invalid
    typedef enum logic [1:0] {
        I = 2'd0,  // Invalid
        S = 2'd1,  // Clean
        M = 2'd2   // Dirty
    } line_state_t;

    typedef struct packed {
        line_state_t          state;
        logic [`TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef logic [`LINE_BITS-1:0] line_t;

endpackage

//--- source/set_ways_array.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module set_ways_array #(
    parameter type entry_t = logic [7:0]
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`INDEX_BITS-1:0] index,
    input  logic                   we,
    input  entry_t                 next_entries [`CACHE_WAYS],
    output entry_t                 cur_entries [`CACHE_WAYS]
);
    entry_t sets [`CACHE_SETS][`CACHE_WAYS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    sets[s][w] <= '0;
                end
            end
        end else if (we) begin
            sets[index] <= next_entries;  // Whole set at once
        end
    end

    assign cur_entries = sets[index];

endmodule

//--- source/victim_select.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module victim_select (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`INDEX_BITS-1:0] index,
    input  cache_pkg::line_state_t entry_states [`CACHE_WAYS],
    input  logic                   plru_touch,
    input  logic [`CACHE_WAYS-1:0] touch_way,
    output logic [`CACHE_WAYS-1:0] victim_way
);
    // Bit 0 root, bit 1 leaf of ways 0/1, bit 2 leaf of ways 2/3
    logic [2:0] plru [`CACHE_SETS];
    logic [2:0] tree;
    logic       found;

    assign tree = plru[index];

    always_comb begin
        victim_way = '0;
        found      = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!found && entry_states[w] == cache_pkg::I) begin
                victim_way[w] = 1'b1;  // Free way first
                found         = 1'b1;
            end
        end
        if (!found) begin
            if (!tree[0]) victim_way = tree[1] ? 4'b0010 : 4'b0001;
            else victim_way = tree[2] ? 4'b1000 : 4'b0100;
        end
    end

    // Point the path away from the way just used
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                plru[s] <= 3'b000;
            end
        end else if (plru_touch) begin
            if (touch_way[0] || touch_way[1]) begin
                plru[index][0] <= 1'b1;
                plru[index][1] <= touch_way[0];
            end else begin
                plru[index][0] <= 1'b0;
                plru[index][2] <= touch_way[2];
            end
        end
    end

    a_touch_onehot: assert property (@(posedge clk) disable iff (reset)
        plru_touch |-> $onehot(touch_way))
        else $error("PLRU touch without a single way");

endmodule

//--- cache/tag_next_state.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module tag_next_state (
    input  cache_pkg::tag_entry_t  tag_cur_state [`CACHE_WAYS],
    input  logic [`ADDR_BITS-1:0]  req_addr,
    input  cache_pkg::op_t         req_op,
    input  logic [`CACHE_WAYS-1:0] sel_way,
    input  logic                   alloc,
    input  logic [`CACHE_WAYS-1:0] victim_way,
    output logic                   hit,
    output logic [`CACHE_WAYS-1:0] hit_way,
    output logic                   victim_dirty,
    output logic [`TAG_BITS-1:0]   victim_tag,
    output cache_pkg::tag_entry_t  tag_next_state [`CACHE_WAYS]
);
    logic [`TAG_BITS-1:0]   req_tag;
    cache_pkg::line_state_t alloc_state;

    assign req_tag     = req_addr[`ADDR_BITS-1 -: `TAG_BITS];
    assign alloc_state = (req_op == cache_pkg::ST) ? cache_pkg::M : cache_pkg::S;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_way[w] = (tag_cur_state[w].state != cache_pkg::I) &&
                         (tag_cur_state[w].tag == req_tag);
        end
    end

    assign hit = |hit_way;

    always_comb begin
        victim_dirty = 1'b0;
        victim_tag   = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (victim_way[w]) begin
                victim_dirty = victim_dirty | (tag_cur_state[w].state == cache_pkg::M);
                victim_tag   = victim_tag | tag_cur_state[w].tag;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            tag_next_state[w] = tag_cur_state[w];
            if (sel_way[w]) begin
                if (alloc) begin
                    tag_next_state[w].state = alloc_state;
                    tag_next_state[w].tag   = req_tag;
                end else if (req_op == cache_pkg::ST) begin
                    tag_next_state[w].state = cache_pkg::M;  // Store hit dirties line
                end
            end
        end
    end

    // A tag may live in one way of a set only
    always_comb begin
        if (!$isunknown(hit_way)) begin
            a_one_hit: assert ($onehot0(hit_way))
                else $error("tag present in several ways");
        end
    end

endmodule

//--- cache/data_next_state.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module data_next_state (
    input  cache_pkg::line_t       data_cur_state [`CACHE_WAYS],
    input  cache_pkg::line_t       mem_rdata,
    input  logic [`WORD_BITS-1:0]  req_wdata,
    input  logic [`ADDR_BITS-1:0]  req_addr,
    input  cache_pkg::size_t       req_size,
    input  cache_pkg::op_t         req_op,
    input  logic [`CACHE_WAYS-1:0] sel_way,
    input  logic                   fill,
    output cache_pkg::line_t       data_next_state [`CACHE_WAYS],
    output logic [`WORD_BITS-1:0]  rdata
);
    cache_pkg::line_t        base;
    cache_pkg::line_t        merged;
    logic [`OFFSET_BITS+2:0] pos;  // Bit position of the access

    // Offset rounded down to the access size keeps the slice inside the line
    always_comb begin
        case (req_size)
            cache_pkg::HALF: pos = {req_addr[`OFFSET_BITS-1:1], 4'b0000};
            cache_pkg::WORD: pos = {req_addr[`OFFSET_BITS-1:2], 5'b00000};
            default:         pos = {req_addr[`OFFSET_BITS-1:0], 3'b000};
        endcase
    end

    always_comb begin
        base = mem_rdata;  // Refill line
        if (!fill) begin
            base = '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (sel_way[w]) base = base | data_cur_state[w];
            end
        end
    end

    always_comb begin
        merged = base;
        if (req_op == cache_pkg::ST) begin
            case (req_size)
                cache_pkg::BYTE: merged[pos +: 8]  = req_wdata[7:0];
                cache_pkg::HALF: merged[pos +: 16] = req_wdata[15:0];
                default:         merged[pos +: 32] = req_wdata;
            endcase
        end
    end

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            data_next_state[w] = sel_way[w] ? merged : data_cur_state[w];
        end
    end

    // Zero-extended load data
    always_comb begin
        case (req_size)
            cache_pkg::BYTE: rdata = {24'b0, merged[pos +: 8]};
            cache_pkg::HALF: rdata = {16'b0, merged[pos +: 16]};
            default:         rdata = merged[pos +: 32];
        endcase
    end

    always_comb begin
        if (!$isunknown({req_size, req_addr[1:0]})) begin
            a_aligned: assert (!(req_size == cache_pkg::HALF && req_addr[0]) &&
                               !(req_size == cache_pkg::WORD && req_addr[1:0] != 2'b00))
                else $error("misaligned access");
        end
    end

endmodule

//--- cache/cache_ctrl.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  cache_pkg::op_t         op,
    input  logic [`ADDR_BITS-1:0]  addr,
    input  cache_pkg::size_t       size,
    input  logic [`WORD_BITS-1:0]  wdata,
    input  logic                   hit,
    input  logic [`CACHE_WAYS-1:0] hit_way,
    input  logic [`CACHE_WAYS-1:0] victim_way,
    input  logic                   victim_dirty,
    input  logic [`TAG_BITS-1:0]   victim_tag,
    input  logic                   mem_rd_done,
    input  logic                   mem_wr_done,
    output logic                   ready,
    output logic                   done,
    output logic [`CACHE_WAYS-1:0] sel_way,
    output logic                   alloc,
    output logic                   tag_we,
    output logic                   data_we,
    output logic                   fill,
    output logic                   plru_touch,
    output logic                   mem_rd,
    output logic                   mem_wr,
    output logic [`ADDR_BITS-1:0]  mem_addr,
    output logic [`ADDR_BITS-1:0]  req_addr,
    output cache_pkg::op_t         req_op,
    output cache_pkg::size_t       req_size,
    output logic [`WORD_BITS-1:0]  req_wdata
);
    typedef enum logic [2:0] {
        IDLE, LOOKUP, WRITEBACK, WB_WAIT, REFILL, RF_WAIT, RETIRE
    } state_t;

    state_t                 state;
    state_t                 state_next;
    logic [`CACHE_WAYS-1:0] way_r;   // Hit way or frozen victim
    logic [`TAG_BITS-1:0]   vtag_r;  // Victim tag for writeback address
    logic                   lookup_hit;
    logic                   in_wb;

    assign lookup_hit = (state == LOOKUP) && hit;
    assign in_wb      = (state == WRITEBACK) || (state == WB_WAIT);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:      if (req) state_next = LOOKUP;
            LOOKUP: begin
                if (hit) state_next = IDLE;
                else if (victim_dirty) state_next = WRITEBACK;
                else state_next = REFILL;
            end
            WRITEBACK: state_next = WB_WAIT;
            WB_WAIT:   if (mem_wr_done) state_next = REFILL;
            REFILL:    state_next = RF_WAIT;
            RF_WAIT:   if (mem_rd_done) state_next = RETIRE;
            RETIRE:    state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            done     <= 1'b0;
            way_r    <= '0;
            req_addr <= '0;
            req_op   <= cache_pkg::LD;
            req_size <= cache_pkg::BYTE;
        end else begin
            state <= state_next;
            done  <= lookup_hit || (state == RETIRE);
            if (state == LOOKUP) way_r <= hit ? hit_way : victim_way;
            if (req && ready) begin
                req_addr <= addr;
                req_op   <= op;
                req_size <= size;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && ready) req_wdata <= wdata;
        if (state == LOOKUP) vtag_r <= victim_tag;
    end

    assign ready      = (state == IDLE);
    assign sel_way    = (state == LOOKUP) ? hit_way : way_r;
    assign alloc      = (state == RETIRE);
    assign fill       = (state == RETIRE);
    assign tag_we     = (lookup_hit && req_op == cache_pkg::ST) || (state == RETIRE);
    assign data_we    = (lookup_hit && req_op == cache_pkg::ST) || (state == RETIRE);
    assign plru_touch = lookup_hit || (state == RETIRE);
    assign mem_wr     = (state == WRITEBACK);
    assign mem_rd     = (state == REFILL);

    // Victim line address while writing back, request line otherwise
    assign mem_addr = in_wb ?
        {vtag_r, req_addr[`OFFSET_BITS +: `INDEX_BITS], {`OFFSET_BITS{1'b0}}} :
        {req_addr[`ADDR_BITS-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};

    a_req_ready: assert property (@(posedge clk) disable iff (reset) req |-> ready)
        else $error("req while busy");

    a_rd_done_wait: assert property (@(posedge clk) disable iff (reset)
        mem_rd_done |-> state == RF_WAIT)
        else $error("mem_rd_done outside refill wait");

    a_size_legal: assert property (@(posedge clk) disable iff (reset)
        req |-> 2'(size) != 2'b11)
        else $error("illegal access size");

endmodule

//--- source/l1_cache_top.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module l1_cache_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  cache_pkg::op_t        op,
    input  logic [`ADDR_BITS-1:0] addr,
    input  cache_pkg::size_t      size,
    input  logic [`WORD_BITS-1:0] wdata,
    output logic                  ready,
    output logic                  done,
    output logic [`WORD_BITS-1:0] rdata,
    output logic                  mem_rd,
    output logic                  mem_wr,
    output logic [`ADDR_BITS-1:0] mem_addr,
    output cache_pkg::line_t      mem_wdata,
    input  logic                  mem_rd_done,
    input  logic                  mem_wr_done,
    input  cache_pkg::line_t      mem_rdata
);
    logic [`ADDR_BITS-1:0]  req_addr;
    cache_pkg::op_t         req_op;
    cache_pkg::size_t       req_size;
    logic [`WORD_BITS-1:0]  req_wdata;
    logic [`INDEX_BITS-1:0] index;
    logic                   hit, victim_dirty;
    logic [`CACHE_WAYS-1:0] hit_way, victim_way, sel_way;
    logic [`TAG_BITS-1:0]   victim_tag;
    logic                   alloc, tag_we, data_we, fill, plru_touch;
    cache_pkg::tag_entry_t  tag_cur [`CACHE_WAYS];
    cache_pkg::tag_entry_t  tag_nxt [`CACHE_WAYS];
    cache_pkg::line_t       data_cur [`CACHE_WAYS];
    cache_pkg::line_t       data_nxt [`CACHE_WAYS];
    cache_pkg::line_state_t entry_states [`CACHE_WAYS];
    cache_pkg::line_t       fill_line;

    assign index = req_addr[`OFFSET_BITS +: `INDEX_BITS];

    // Refill data is only valid with the done pulse
    always_ff @(posedge clk) begin
        if (mem_rd_done) fill_line <= mem_rdata;
    end

    always_comb begin
        mem_wdata = '0;  // Victim line
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (sel_way[w]) mem_wdata = mem_wdata | data_cur[w];
            entry_states[w] = tag_cur[w].state;
        end
    end

    cache_ctrl u_ctrl (
        .clk(clk), .reset(reset), .req(req), .op(op), .addr(addr), .size(size),
        .wdata(wdata), .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .mem_rd_done(mem_rd_done), .mem_wr_done(mem_wr_done), .ready(ready),
        .done(done), .sel_way(sel_way), .alloc(alloc), .tag_we(tag_we),
        .data_we(data_we), .fill(fill), .plru_touch(plru_touch), .mem_rd(mem_rd),
        .mem_wr(mem_wr), .mem_addr(mem_addr), .req_addr(req_addr), .req_op(req_op),
        .req_size(req_size), .req_wdata(req_wdata)
    );

    tag_next_state u_tag_next (
        .tag_cur_state(tag_cur), .req_addr(req_addr), .req_op(req_op),
        .sel_way(sel_way), .alloc(alloc), .victim_way(victim_way), .hit(hit),
        .hit_way(hit_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .tag_next_state(tag_nxt)
    );

    data_next_state u_data_next (
        .data_cur_state(data_cur), .mem_rdata(fill_line), .req_wdata(req_wdata),
        .req_addr(req_addr), .req_size(req_size), .req_op(req_op),
        .sel_way(sel_way), .fill(fill), .data_next_state(data_nxt), .rdata(rdata)
    );

    set_ways_array #(.entry_t(cache_pkg::tag_entry_t)) u_tag_array (
        .clk(clk), .reset(reset), .index(index), .we(tag_we),
        .next_entries(tag_nxt), .cur_entries(tag_cur)
    );

    set_ways_array #(.entry_t(cache_pkg::line_t)) u_data_array (
        .clk(clk), .reset(reset), .index(index), .we(data_we),
        .next_entries(data_nxt), .cur_entries(data_cur)
    );

    victim_select u_victim (
        .clk(clk), .reset(reset), .index(index), .entry_states(entry_states),
        .plru_touch(plru_touch), .touch_way(sel_way), .victim_way(victim_way)
    );

endmodule

//--- tb/mem_model.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module mem_model (
    input  logic                  clk,
    input  logic                  mem_rd,
    input  logic                  mem_wr,
    input  logic [`ADDR_BITS-1:0] mem_addr,
    input  cache_pkg::line_t      mem_wdata,
    output logic                  mem_rd_done,
    output logic                  mem_wr_done,
    output cache_pkg::line_t      mem_rdata
);
    cache_pkg::line_t                   lines [logic [`ADDR_BITS-`OFFSET_BITS-1:0]];  // Written lines
    logic [15:0]                        lfsr_state = 16'd45517;
    logic [`ADDR_BITS-`OFFSET_BITS-1:0] ln;

    function automatic logic [31:0] pattern_word(logic [31:0] a);
        return (a ^ 32'h5A3C_96E1) + {a[15:0], a[31:16]};
    endfunction

    function automatic cache_pkg::line_t peek_line(logic [`ADDR_BITS-`OFFSET_BITS-1:0] n);
        cache_pkg::line_t l;
        if (lines.exists(n)) return lines[n];
        for (int i = 0; i < 16; i++) begin
            l[32*i +: 32] = pattern_word({n, 4'(i), 2'b00});  // Never written
        end
        return l;
    endfunction

    // Reply latency of 1 to 8 cycles
    function automatic int reply_delay();
        int d;
        d = 0;
        for (int i = 0; i < 3; i++) begin
            d          = 2 * d + int'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
        end
        return d + 1;
    endfunction

    initial begin
        mem_rd_done = 1'b0;
        mem_wr_done = 1'b0;
        mem_rdata   = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_rd_done = 1'b0;
            mem_wr_done = 1'b0;
            ln          = mem_addr[`ADDR_BITS-1:`OFFSET_BITS];
            if (mem_wr) begin
                lines[ln] = mem_wdata;
                repeat (reply_delay()) @(posedge clk);
                #1;
                mem_wr_done = 1'b1;
            end else if (mem_rd) begin
                repeat (reply_delay()) @(posedge clk);
                #1;
                mem_rdata   = peek_line(ln);  // Held until the next refill
                mem_rd_done = 1'b1;
            end
        end
    end

endmodule

//--- tb/l1_cache_tb.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module l1_cache_tb;
    localparam int mix_ops           = 200;
    localparam int directed_ops      = 90;
    localparam int worst_miss_cycles = 30;
    localparam int watchdog_ns       = (8 + (mix_ops + directed_ops) * worst_miss_cycles) * 8;

    logic                  clk;
    logic                  reset;
    logic                  req;
    cache_pkg::op_t        op;
    logic [`ADDR_BITS-1:0] addr;
    cache_pkg::size_t      size;
    logic [`WORD_BITS-1:0] wdata;
    logic                  ready, done, mem_rd, mem_wr, mem_rd_done, mem_wr_done;
    logic [`WORD_BITS-1:0] rdata;
    logic [`ADDR_BITS-1:0] mem_addr;
    cache_pkg::line_t      mem_wdata, mem_rdata;

    logic [7:0]         shadow [logic [31:0]];  // Bytes written by stores
    bit                 touched [logic [25:0]];
    bit [`TAG_BITS-1:0] m_tag [`CACHE_SETS][`CACHE_WAYS];
    bit                 m_valid [`CACHE_SETS][`CACHE_WAYS];
    bit                 m_dirty [`CACHE_SETS][`CACHE_WAYS];
    bit [2:0]           m_plru [`CACHE_SETS];
    logic [15:0]        lfsr_state = 16'd45517;

    l1_cache_top dut_i (.*);
    mem_model mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    task automatic check_equal(input string what, input cache_pkg::line_t got,
                               input cache_pkg::line_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
        end
        return r;
    endfunction

    function automatic logic [31:0] init_word(logic [31:0] a);
        return (a ^ 32'h5A3C_96E1) + {a[15:0], a[31:16]};
    endfunction

    function automatic logic [7:0] expect_byte(logic [31:0] a);
        logic [31:0] w;
        if (shadow.exists(a)) return shadow[a];
        w = init_word({a[31:2], 2'b00});
        return w[8*a[1:0] +: 8];
    endfunction

    function automatic cache_pkg::line_t shadow_line(logic [31:0] base);
        cache_pkg::line_t l;
        for (int i = 0; i < 64; i++) begin
            l[8*i +: 8] = expect_byte(base + 32'(i));
        end
        return l;
    endfunction

    // Free way first, then the tree
    function automatic logic [1:0] pick_victim(logic [3:0] s);
        for (int w = 0; w < 4; w++) begin
            if (!m_valid[s][w]) return 2'(w);
        end
        if (!m_plru[s][0]) return m_plru[s][1] ? 2'd1 : 2'd0;
        return m_plru[s][2] ? 2'd3 : 2'd2;
    endfunction

    function automatic void point_plru_away(logic [3:0] s, logic [1:0] w);
        if (!w[1]) begin
            m_plru[s][0] = 1'b1;
            m_plru[s][1] = !w[0];
        end else begin
            m_plru[s][0] = 1'b0;
            m_plru[s][2] = !w[0];
        end
    endfunction

    task automatic access(input cache_pkg::op_t kind, input logic [31:0] a,
                          input cache_pkg::size_t sz, input logic [31:0] wd);
        logic [3:0]       s;
        logic [1:0]       way;
        bit               hit_exp;
        bit               wb_exp;
        bit               wr_seen;
        bit               rd_seen;
        int               nbytes;
        int               cycles;
        logic [31:0]      wb_addr;
        logic [31:0]      exp_rdata;
        cache_pkg::line_t wb_line;
        s       = a[9:6];
        nbytes  = (sz == cache_pkg::BYTE) ? 1 : (sz == cache_pkg::HALF) ? 2 : 4;
        hit_exp = 1'b0;
        way     = pick_victim(s);
        for (int w = 0; w < 4; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == a[31:10]) begin
                hit_exp = 1'b1;
                way     = 2'(w);
            end
        end
        wb_exp  = !hit_exp && m_valid[s][way] && m_dirty[s][way];
        wb_addr = {m_tag[s][way], s, 6'd0};
        wb_line = shadow_line(wb_addr);  // Victim contents before this store
        touched[a[31:6]] = 1'b1;
        req   = 1'b1;
        op    = kind;
        addr  = a;
        size  = sz;
        wdata = wd;
        @(posedge clk);
        #1;
        req     = 1'b0;
        cycles  = 1;
        wr_seen = 1'b0;
        rd_seen = 1'b0;
        while (!done) begin
            check_equal("ready while busy", cache_pkg::line_t'(ready), 0);
            if (mem_wr) begin
                check_equal("mem_wr allowed", cache_pkg::line_t'(wb_exp && !rd_seen), 1);
                check_equal("writeback mem_addr", cache_pkg::line_t'(mem_addr),
                            cache_pkg::line_t'(wb_addr));
                check_equal("writeback mem_wdata", mem_wdata, wb_line);
                wr_seen = 1'b1;
            end
            if (mem_rd) begin
                check_equal("mem_rd allowed", cache_pkg::line_t'(!hit_exp && wr_seen == wb_exp), 1);
                check_equal("refill mem_addr", cache_pkg::line_t'(mem_addr),
                            cache_pkg::line_t'({a[31:6], 6'd0}));
                rd_seen = 1'b1;
            end
            if (cycles > worst_miss_cycles) begin
                $display("Request to address %h never finished", a);
                $display("CHECKS FAILED");
                $fatal(1, "request timeout");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        check_equal("ready at done", cache_pkg::line_t'(ready), 1);
        check_equal("refill seen", cache_pkg::line_t'(rd_seen), cache_pkg::line_t'(!hit_exp));
        check_equal("writeback seen", cache_pkg::line_t'(wr_seen), cache_pkg::line_t'(wb_exp));
        if (hit_exp) check_equal("hit latency", cache_pkg::line_t'(cycles), 2);
        if (kind == cache_pkg::ST) begin
            for (int i = 0; i < nbytes; i++)
                shadow[a + 32'(i)] = wd[8*i +: 8];
        end else begin
            exp_rdata = '0;
            for (int i = 0; i < nbytes; i++)
                exp_rdata[8*i +: 8] = expect_byte(a + 32'(i));
            check_equal("load rdata", cache_pkg::line_t'(rdata), cache_pkg::line_t'(exp_rdata));
        end
        m_dirty[s][way] = (hit_exp && m_dirty[s][way]) || kind == cache_pkg::ST;
        m_valid[s][way] = 1'b1;
        m_tag[s][way]   = a[31:10];
        point_plru_away(s, way);
    endtask

    task automatic first_load_after_reset();
        check_equal("ready after reset", cache_pkg::line_t'(ready), 1);
        check_equal("done after reset", cache_pkg::line_t'(done), 0);
        check_equal("mem_rd after reset", cache_pkg::line_t'(mem_rd), 0);
        check_equal("mem_wr after reset", cache_pkg::line_t'(mem_wr), 0);
        access(cache_pkg::LD, {22'h0ABC, 4'd1, 6'h10}, cache_pkg::WORD, '0);
        check_equal("first load", cache_pkg::line_t'(rdata),
                    cache_pkg::line_t'(init_word({22'h0ABC, 4'd1, 6'h10})));
    endtask

    task automatic store_merge_hits();
        logic [31:0] base;
        base = {22'h0ABC, 4'd1, 6'd0};
        access(cache_pkg::ST, base + 32'h11, cache_pkg::BYTE, 32'h0000_00C7);
        access(cache_pkg::ST, base + 32'h22, cache_pkg::HALF, 32'h0000_BEEF);
        access(cache_pkg::ST, base + 32'h28, cache_pkg::WORD, 32'h1357_9BDF);
        access(cache_pkg::LD, base + 32'h10, cache_pkg::WORD, '0);
        access(cache_pkg::LD, base + 32'h22, cache_pkg::HALF, '0);
        access(cache_pkg::LD, base + 32'h28, cache_pkg::WORD, '0);
        access(cache_pkg::LD, base + 32'h11, cache_pkg::BYTE, '0);
    endtask

    task automatic dirty_victim_eviction();
        for (int k = 0; k < 5; k++)
            access(cache_pkg::ST, {22'h10 + 22'(k), 4'd5, 6'(4 * k)}, cache_pkg::WORD,
                   32'hA000_0000 + 32'(k));
    endtask

    task automatic clean_victim_eviction();
        logic [31:0] gone;
        for (int k = 0; k < 4; k++)
            access(cache_pkg::LD, {22'h20 + 22'(k), 4'd9, 6'd8}, cache_pkg::WORD, '0);
        gone = {m_tag[9][pick_victim(4'd9)], 4'd9, 6'd8};
        access(cache_pkg::LD, {22'h24, 4'd9, 6'd8}, cache_pkg::WORD, '0);
        access(cache_pkg::LD, gone, cache_pkg::WORD, '0);
        check_equal("reloaded word", cache_pkg::line_t'(rdata),
                    cache_pkg::line_t'(init_word(gone)));
    endtask

    task automatic random_load_store_mix();
        logic [3:0]       s;
        logic [21:0]      t;
        logic [5:0]       off;
        logic [1:0]       r;
        cache_pkg::size_t sz;
        cache_pkg::op_t   kind;
        for (int n = 0; n < mix_ops; n++) begin
            s    = rand_bits(1) ? 4'd3 : 4'd2;
            t    = 22'h100 + 22'(rand_bits(3));  // Eight tags over two sets
            r    = 2'(rand_bits(2));
            sz   = (r == 2'd3) ? cache_pkg::WORD : cache_pkg::size_t'(r);
            off  = 6'(rand_bits(6));
            kind = rand_bits(1) ? cache_pkg::ST : cache_pkg::LD;
            if (sz == cache_pkg::HALF) off[0] = 1'b0;
            if (sz == cache_pkg::WORD) off[1:0] = 2'b00;
            access(kind, {t, s, off}, sz, rand_bits(32));
        end
    endtask

    // Four fresh tags per set push every older line out
    task automatic flush_and_compare_memory();
        for (int s = 0; s < 16; s++) begin
            for (int k = 0; k < 4; k++)
                access(cache_pkg::LD, {22'h3FFFF0 + 22'(k), 4'(s), 6'd0}, cache_pkg::WORD, '0);
        end
        foreach (touched[ln])
            check_equal("memory line", mem_i.peek_line(ln), shadow_line({ln, 6'd0}));
    endtask

    initial begin
        reset = 1'b1;
        req   = 1'b0;
        op    = cache_pkg::LD;
        addr  = '0;
        size  = cache_pkg::BYTE;
        wdata = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        first_load_after_reset();
        store_merge_hits();
        dirty_victim_eviction();
        clean_victim_eviction();
        random_load_store_mix();
        flush_and_compare_memory();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- l1_cache.f
+incdir+common
common/cache_pkg.sv
source/set_ways_array.sv
source/victim_select.sv
cache/tag_next_state.sv
cache/data_next_state.sv
cache/cache_ctrl.sv
source/l1_cache_top.sv
tb/mem_model.sv
tb/l1_cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= l1_cache_tb
FILELIST  ?= l1_cache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  make help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
